//--- verif/da_testdata_packets.txt
// Per test: input count, report word count, ctl_write count, dirchan, back-pressure flag,
// then host_in words, expected host_out words, expected ctl_write words as {slot, data}
00000006
// Echo, slot 2, five words
00000008 0000000B 00000000 00000000 00000000
0002 0040 0005 1111 2222 3333 4444 5555
0002 0041 0000 0005 1111 2222 3333 4444 5555 0001 0047
// Control write, slot 1, good checksum, no report
00000009 00000000 00000003 00000000 00000000
0001 0020 0000 0003 0100 0200 0300 0000 0600
00010100 00010200 00010300
// Control write, slot 3, bad checksum, writes then error report
00000008 0000000A 00000002 00000000 00000000
0003 0020 0000 0002 ABCD 1234 0000 BE02
0003 0021 0000 0004 0000 BE02 0000 BE01 0001 7C2B
0003ABCD 00031234
// Dirchan read, slot 0, dirchan A5
00000002 00000007 00000000 000000A5 00000000
0000 0010
0000 0011 0000 0001 00A5 0000 00B7
// Long echo, slot 1, 32 words under random back-pressure
00000023 00000026 00000000 00000000 00000001
0001 0040 0020
1001 1002 1003 1004 1005 1006 1007 1008 1009 100A 100B 100C 100D 100E 100F 1010
1011 1012 1013 1014 1015 1016 1017 1018 1019 101A 101B 101C 101D 101E 101F 1020
0001 0041 0000 0020
1001 1002 1003 1004 1005 1006 1007 1008 1009 100A 100B 100C 100D 100E 100F 1010
1011 1012 1013 1014 1015 1016 1017 1018 1019 101A 101B 101C 101D 101E 101F 1020
0002 0272
// Slot 4 rejected, then dirchan read on slot 1 with dirchan 3C
00000004 00000007 00000000 0000003C 00000000
0004 0010 0001 0010
0001 0011 0000 0001 003C 0000 004F

//--- filelist.f
src/da_proto_pkg.sv
src/da_report_pkg.sv
src/da_payload_fifo.sv
src/da_report_framer.sv
src/da_cmd_parser.sv
src/da_host_core.sv
verif/tb_da_host_core.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the host core testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    --top-module tb_da_host_core -Mdir "$BUILD_DIR" -f filelist.f
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

"./$BUILD_DIR/Vtb_da_host_core" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "Test failures found" "$LOG"; then
    echo "Simulation reported failures"
    exit 1
fi

echo "Simulation finished without failures"
exit 0

//--- verif/tb_da_host_core.sv
/* Testbench for the host command front end with clock, reset, packets and expected
   words from the data file, random host_out back-pressure and typed compare tasks */

`timescale 1ns/100ps

module tb_da_host_core;

    localparam int PAYLOAD_DEPTH = 32;
    localparam int NUM_SLOTS     = 4;
    localparam int TDATA_SIZE    = 512;
    localparam int WAIT_LIMIT    = 2000;
    localparam int QUIET_CYCLES  = 20;

    logic                       clk_core;
    logic                       reset;
    da_proto_pkg::host_stream_t host_in;
    logic                       host_in_ready;
    da_proto_pkg::host_stream_t host_out;
    logic                       host_out_ready;
    logic [7:0]                 dirchan;
    da_report_pkg::ctl_write_t  ctl_write;

    // Flat record stream from the data file with the test count in entry 0
    logic [31:0] tdata [TDATA_SIZE];
    int          rd_idx;
    bit          backpressure;
    int          errors;
    int          tests_passed;
    int          tests_failed;

    // Words seen leaving the DUT during the current test
    da_proto_pkg::host_word_t  got_words [$];
    da_report_pkg::ctl_write_t got_ctl [$];

    da_host_core #(
        .PAYLOAD_DEPTH(PAYLOAD_DEPTH),
        .NUM_SLOTS    (NUM_SLOTS)
    ) dut (
        .clk_core      (clk_core),
        .reset         (reset),
        .host_in       (host_in),
        .host_in_ready (host_in_ready),
        .host_out      (host_out),
        .host_out_ready(host_out_ready),
        .dirchan       (dirchan),
        .ctl_write     (ctl_write)
    );

    // 20 ns clock
    always #10 clk_core = ~clk_core;

    // Ready low about one cycle in four when back-pressure is on
    always @(posedge clk_core) begin
        #2;
        if (backpressure) begin
            host_out_ready = ($urandom % 4) != 0;
        end else begin
            host_out_ready = 1'b1;
        end
    end

    // Falling edge sees the values that the next rising edge transfers
    always @(negedge clk_core) begin
        if (!reset) begin
            if (host_out.valid && host_out_ready) begin
                got_words.push_back(host_out.data);
            end
            if (ctl_write.valid) begin
                got_ctl.push_back(ctl_write);
            end
        end
    end

    task automatic check_host_word(input string name, input da_proto_pkg::host_word_t got,
                                   input da_proto_pkg::host_word_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_ctl_write(input int idx, input da_report_pkg::ctl_write_t got,
                                   input da_report_pkg::ctl_write_t exp);
        if (got !== exp) begin
            $display("MISMATCH ctl_write[%0d]: got %h expected %h", idx, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // Outputs idle in reset and ready up one edge after release
    task automatic check_reset_release();
        int errs_before;
        errs_before = errors;
        check_flag("host_in_ready", host_in_ready, 1'b0);
        check_flag("host_out.valid", host_out.valid, 1'b0);
        check_flag("ctl_write.valid", ctl_write.valid, 1'b0);
        reset = 1'b0;
        @(posedge clk_core);
        #2;
        check_flag("host_in_ready", host_in_ready, 1'b1);
        if (errors == errs_before) begin
            $display("reset check: passed");
            tests_passed++;
        end else begin
            $display("reset check: failed with %0d errors", errors - errs_before);
            tests_failed++;
        end
    endtask

    // Holds one word on host_in until the DUT takes it
    task automatic send_word(input da_proto_pkg::host_word_t w, output bit ok);
        int waited;
        bit taken;
        host_in.valid = 1'b1;
        host_in.data  = w;
        taken  = 1'b0;
        waited = 0;
        while (!taken && waited < WAIT_LIMIT) begin
            // Ready comes from flops and keeps its value up to the next edge
            taken = host_in_ready;
            @(posedge clk_core);
            #2;
            waited++;
        end
        host_in.valid = 1'b0;
        ok = taken;
    endtask

    task automatic run_test(input int test_num);
        int  n_in;
        int  n_rpt;
        int  n_ctl;
        int  waited;
        int  errs_before;
        bit  ok;
        da_report_pkg::ctl_write_t exp_ctl;
        errs_before = errors;
        n_in  = int'(tdata[rd_idx]);
        n_rpt = int'(tdata[rd_idx + 1]);
        n_ctl = int'(tdata[rd_idx + 2]);
        dirchan      = tdata[rd_idx + 3][7:0];
        backpressure = tdata[rd_idx + 4][0];
        rd_idx += 5;
        if (rd_idx + n_in + n_rpt + n_ctl > TDATA_SIZE) begin
            $display("test %0d: record runs past the end of the test data", test_num);
            errors++;
            tests_failed++;
            return;
        end
        got_words.delete();
        got_ctl.delete();

        for (int i = 0; i < n_in; i++) begin
            send_word(tdata[rd_idx + i][15:0], ok);
            if (!ok) begin
                $display("test %0d: input word %0d was never accepted", test_num, i);
                errors++;
                break;
            end
        end
        rd_idx += n_in;

        // Report words and strobes arrive with a variable latency
        waited = 0;
        while ((got_words.size() < n_rpt || got_ctl.size() < n_ctl) && waited < WAIT_LIMIT) begin
            @(posedge clk_core);
            #2;
            waited++;
        end
        if (got_words.size() < n_rpt || got_ctl.size() < n_ctl) begin
            $display("test %0d: timed out waiting for report words or control writes",
                     test_num);
            errors++;
        end

        // Quiet window catches reports or writes that should not be there
        for (int i = 0; i < QUIET_CYCLES; i++) begin
            @(posedge clk_core);
            #2;
        end

        if (got_words.size() != n_rpt) begin
            $display("test %0d: expected %0d report words, received %0d",
                     test_num, n_rpt, got_words.size());
            errors++;
        end
        for (int i = 0; i < n_rpt && i < got_words.size(); i++) begin
            check_host_word($sformatf("host_out.data[%0d]", i), got_words[i],
                            tdata[rd_idx + i][15:0]);
        end
        rd_idx += n_rpt;

        if (got_ctl.size() != n_ctl) begin
            $display("test %0d: expected %0d control writes, received %0d",
                     test_num, n_ctl, got_ctl.size());
            errors++;
        end
        for (int i = 0; i < n_ctl && i < got_ctl.size(); i++) begin
            // File word is slot in bits 23:16 and data in the low half
            exp_ctl.valid = 1'b1;
            exp_ctl.slot  = tdata[rd_idx + i][23:16];
            exp_ctl.data  = tdata[rd_idx + i][15:0];
            check_ctl_write(i, got_ctl[i], exp_ctl);
        end
        rd_idx += n_ctl;

        if (errors == errs_before) begin
            $display("test %0d: passed", test_num);
            tests_passed++;
        end else begin
            $display("test %0d: failed with %0d errors", test_num, errors - errs_before);
            tests_failed++;
        end
    endtask

    initial begin
        int num_tests;
        clk_core       = 1'b0;
        reset          = 1'b1;
        host_in        = '0;
        host_out_ready = 1'b1;
        dirchan        = '0;
        backpressure   = 1'b0;
        errors         = 0;
        tests_passed   = 0;
        tests_failed   = 0;
        rd_idx         = 1;
        num_tests      = 0;
        void'($urandom(32'h0d63_381a));

        $readmemh("verif/da_testdata_packets.txt", tdata);
        if ($isunknown(tdata[0]) || tdata[0] == '0 || tdata[0] > 32'd64) begin
            $display("Test data file is missing or holds no valid test count");
            errors++;
        end else begin
            num_tests = int'(tdata[0]);
        end

        repeat (3) @(posedge clk_core);
        #2;
        check_reset_release();

        for (int t = 1; t <= num_tests; t++) begin
            run_test(t);
        end

        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_passed + tests_failed, tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- src/da_host_core.sv
/* Host command front end top: parser, payload FIFO and report framer */

`timescale 1ns/100ps

module da_host_core #(
    parameter int PAYLOAD_DEPTH = 32,
    parameter int NUM_SLOTS     = 4
) (
    input  logic                       clk_core,
    input  logic                       reset,
    input  da_proto_pkg::host_stream_t host_in,
    output logic                       host_in_ready,
    output da_proto_pkg::host_stream_t host_out,
    input  logic                       host_out_ready,
    input  logic [7:0]                 dirchan,
    output da_report_pkg::ctl_write_t  ctl_write
);

    // Parser to FIFO
    logic                     push;
    da_proto_pkg::host_word_t push_word;

    // FIFO to framer
    logic                     pop;
    logic                     empty;
    da_proto_pkg::host_word_t head_word;

    // Parser to framer handshake
    logic                       report_start;
    logic                       busy;
    da_report_pkg::report_req_t report_req;

    da_cmd_parser #(
        .PAYLOAD_DEPTH(PAYLOAD_DEPTH),
        .NUM_SLOTS    (NUM_SLOTS)
    ) u_parser (
        .clk_core     (clk_core),
        .reset        (reset),
        .host_in      (host_in),
        .host_in_ready(host_in_ready),
        .dirchan      (dirchan),
        .ctl_write    (ctl_write),
        .push         (push),
        .push_word    (push_word),
        .report_start (report_start),
        .report_req   (report_req),
        .busy         (busy)
    );

    da_payload_fifo #(
        .PAYLOAD_DEPTH(PAYLOAD_DEPTH)
    ) u_payload (
        .clk_core (clk_core),
        .reset    (reset),
        .push     (push),
        .push_word(push_word),
        .pop      (pop),
        .head_word(head_word),
        .empty    (empty)
    );

    da_report_framer u_framer (
        .clk_core      (clk_core),
        .reset         (reset),
        .report_start  (report_start),
        .report_req    (report_req),
        .busy          (busy),
        .pop           (pop),
        .head_word     (head_word),
        .empty         (empty),
        .host_out      (host_out),
        .host_out_ready(host_out_ready)
    );

endmodule

//--- src/da_cmd_parser.sv
/* Host packet parser: slot and command decode, echo, checksummed control
   write and dirchan read, payload push and report requests */

`timescale 1ns/100ps

module da_cmd_parser #(
    parameter int PAYLOAD_DEPTH = 32,
    parameter int NUM_SLOTS     = 4
) (
    input  logic                       clk_core,
    input  logic                       reset,
    input  da_proto_pkg::host_stream_t host_in,
    output logic                       host_in_ready,
    input  logic [7:0]                 dirchan,
    output da_report_pkg::ctl_write_t  ctl_write,
    output logic                       push,
    output da_proto_pkg::host_word_t   push_word,
    output logic                       report_start,
    output da_report_pkg::report_req_t report_req,
    input  logic                       busy
);

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_CMD,
        ST_ECHO_CNT,
        ST_ECHO_DATA,
        ST_LEN,
        ST_CTL_DATA,
        ST_CSUM,
        ST_ERR,
        ST_WAIT
    } state_t;

    state_t state;

    logic                      accept;
    logic [7:0]                slot_q;
    logic                      slot_ok_q;
    logic [1:0]                sub_q;
    logic [1:0]                err_idx;
    da_proto_pkg::report_len_t cnt_q;
    da_proto_pkg::report_len_t echo_n;
    da_proto_pkg::report_len_t ctl_len;
    da_proto_pkg::host_word_t  hold_q;
    da_proto_pkg::host_word_t  rcv_lo_q;
    da_proto_pkg::checksum_t   calc_q;

    // Held off during reset, while a report is pending and while framing
    assign host_in_ready = (state != ST_WAIT) && (state != ST_ERR) && !busy;
    assign accept = host_in.valid && host_in_ready;

    // Echo count never exceeds what the payload FIFO can hold
    always_comb begin
        if (da_proto_pkg::report_len_t'(host_in.data) >
                da_proto_pkg::report_len_t'(PAYLOAD_DEPTH)) begin
            echo_n = da_proto_pkg::report_len_t'(PAYLOAD_DEPTH);
        end else begin
            echo_n = da_proto_pkg::report_len_t'(host_in.data);
        end
    end

    // Low 24 bits of the two length words
    assign ctl_len = {hold_q[7:0], host_in.data};

    always_ff @(posedge clk_core) begin
        if (reset) begin
            // Leaves through ST_WAIT so ready rises one cycle after reset
            state           <= ST_WAIT;
            push            <= 1'b0;
            report_start    <= 1'b0;
            ctl_write.valid <= 1'b0;
            sub_q           <= '0;
            err_idx         <= '0;
        end else begin
            push            <= 1'b0;
            report_start    <= 1'b0;
            ctl_write.valid <= 1'b0;

            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        slot_q    <= host_in.data[7:0];
                        slot_ok_q <= host_in.data < 16'(NUM_SLOTS);
                        state     <= ST_CMD;
                    end
                end

                ST_CMD: begin
                    if (accept) begin
                        state <= ST_IDLE;
                        // Bad slot or unknown command drops the packet silently
                        if (slot_ok_q) begin
                            case (host_in.data[7:0])
                                da_proto_pkg::CMD_DIRCHAN_READ: begin
                                    push         <= 1'b1;
                                    push_word    <= {8'h00, dirchan};
                                    report_start <= 1'b1;
                                    report_req   <= {slot_q, da_proto_pkg::RPT_DIRCHAN,
                                                     da_proto_pkg::report_len_t'(1)};
                                    state        <= ST_WAIT;
                                end
                                da_proto_pkg::CMD_CTL_WRITE: begin
                                    sub_q  <= '0;
                                    calc_q <= '0;
                                    state  <= ST_LEN;
                                end
                                da_proto_pkg::CMD_ECHO_SEND: begin
                                    state <= ST_ECHO_CNT;
                                end
                                default: begin
                                    state <= ST_IDLE;
                                end
                            endcase
                        end
                    end
                end

                ST_ECHO_CNT: begin
                    if (accept) begin
                        cnt_q      <= echo_n;
                        report_req <= {slot_q, da_proto_pkg::RPT_ECHO, echo_n};
                        if (echo_n == '0) begin
                            // Empty echo, header and footer only
                            report_start <= 1'b1;
                            state        <= ST_WAIT;
                        end else begin
                            state <= ST_ECHO_DATA;
                        end
                    end
                end

                ST_ECHO_DATA: begin
                    if (accept) begin
                        push      <= 1'b1;
                        push_word <= host_in.data;
                        cnt_q     <= cnt_q - 1'b1;
                        if (cnt_q == da_proto_pkg::report_len_t'(1)) begin
                            report_start <= 1'b1;
                            state        <= ST_WAIT;
                        end
                    end
                end

                ST_LEN: begin
                    if (accept) begin
                        hold_q <= host_in.data;
                        sub_q  <= sub_q + 1'b1;
                        if (sub_q == 2'(da_proto_pkg::LENGTH_WORDS - 1)) begin
                            cnt_q <= ctl_len;
                            sub_q <= '0;
                            state <= (ctl_len == '0) ? ST_CSUM : ST_CTL_DATA;
                        end
                    end
                end

                ST_CTL_DATA: begin
                    if (accept) begin
                        // Written out as received, a bad checksum comes too late to stop it
                        ctl_write.valid <= 1'b1;
                        ctl_write.slot  <= slot_q;
                        ctl_write.data  <= host_in.data;
                        calc_q          <= calc_q + da_proto_pkg::checksum_t'(host_in.data);
                        cnt_q           <= cnt_q - 1'b1;
                        if (cnt_q == da_proto_pkg::report_len_t'(1)) begin
                            state <= ST_CSUM;
                        end
                    end
                end

                ST_CSUM: begin
                    if (accept) begin
                        hold_q <= host_in.data;
                        sub_q  <= sub_q + 1'b1;
                        if (sub_q == 2'(da_proto_pkg::CHECKSUM_WORDS - 1)) begin
                            sub_q <= '0;
                            state <= ST_IDLE;
                            if ({hold_q, host_in.data} != calc_q) begin
                                // First error word goes out now, three more follow
                                rcv_lo_q     <= host_in.data;
                                push         <= 1'b1;
                                push_word    <= hold_q;
                                report_start <= 1'b1;
                                report_req   <= {slot_q, da_proto_pkg::RPT_CHECKSUM_ERROR,
                                                 da_proto_pkg::report_len_t'(4)};
                                err_idx      <= 2'd1;
                                state        <= ST_ERR;
                            end
                        end
                    end
                end

                ST_ERR: begin
                    // Received low, then calculated high and low
                    push    <= 1'b1;
                    err_idx <= err_idx + 1'b1;
                    case (err_idx)
                        2'd1:    push_word <= rcv_lo_q;
                        2'd2:    push_word <= calc_q[31:16];
                        default: push_word <= calc_q[15:0];
                    endcase
                    if (err_idx == 2'd3) begin
                        state <= ST_WAIT;
                    end
                end

                ST_WAIT: begin
                    // Framer raises busy the cycle after the start strobe
                    if (!busy && !report_start) begin
                        state <= ST_IDLE;
                    end
                end

                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // A new report may only start once the framer has finished the last one
    a_start_not_busy: assert property (
        @(posedge clk_core) disable iff (reset) report_start |-> !busy
    );

endmodule

//--- src/da_report_framer.sv
/* Report framer: header, payload from the FIFO and checksum footer
   onto the host output stream */

`timescale 1ns/100ps

module da_report_framer (
    input  logic                       clk_core,
    input  logic                       reset,
    input  logic                       report_start,
    input  da_report_pkg::report_req_t report_req,
    output logic                       busy,
    output logic                       pop,
    input  da_proto_pkg::host_word_t   head_word,
    input  logic                       empty,
    output da_proto_pkg::host_stream_t host_out,
    input  logic                       host_out_ready
);

    da_report_pkg::report_req_t req_q;
    da_proto_pkg::checksum_t    sum_q;

    // Index of the report word on the output now
    logic [24:0] idx_q;
    logic [24:0] payload_end;
    logic        in_header;
    logic        in_payload;
    logic        last_word;
    logic        xfer;

    assign payload_end = 25'(da_proto_pkg::HEADER_WORDS) + 25'(req_q.len);
    assign in_header   = idx_q < 25'(da_proto_pkg::HEADER_WORDS);
    assign in_payload  = !in_header && (idx_q < payload_end);
    assign last_word   = idx_q == payload_end + 25'(da_proto_pkg::CHECKSUM_WORDS - 1);

    // Word select follows the index, payload waits for a FIFO word
    always_comb begin
        host_out.valid = busy;
        host_out.data  = '0;
        if (in_header) begin
            case (idx_q[1:0])
                2'd0:    host_out.data = {8'h00, req_q.slot};
                2'd1:    host_out.data = {8'h00, req_q.code};
                2'd2:    host_out.data = {8'h00, req_q.len[23:16]};
                default: host_out.data = req_q.len[15:0];
            endcase
        end else if (in_payload) begin
            host_out.valid = busy && !empty;
            host_out.data  = head_word;
        end else if (idx_q == payload_end) begin
            host_out.data = sum_q[31:16];
        end else begin
            host_out.data = sum_q[15:0];
        end
    end

    assign xfer = host_out.valid && host_out_ready;

    // FIFO advances only when its head word leaves
    assign pop = xfer && in_payload;

    // Request captured here, parser is free to change its copy
    always_ff @(posedge clk_core) begin
        if (report_start) begin
            req_q <= report_req;
        end
    end

    always_ff @(posedge clk_core) begin
        if (reset) begin
            busy  <= 1'b0;
            idx_q <= '0;
            sum_q <= '0;
        end else if (report_start) begin
            busy  <= 1'b1;
            idx_q <= '0;
            sum_q <= '0;
        end else if (xfer) begin
            idx_q <= idx_q + 1'b1;
            // Sum frozen once the footer starts
            if (in_header || in_payload) begin
                sum_q <= sum_q + da_proto_pkg::checksum_t'(host_out.data);
            end
            if (last_word) begin
                busy <= 1'b0;
            end
        end
    end

    // A stalled word must not change under the host
    a_out_stable: assert property (
        @(posedge clk_core) disable iff (reset)
        host_out.valid && !host_out_ready |=> host_out.valid && $stable(host_out.data)
    );

endmodule

//--- src/da_payload_fifo.sv
/* Read-ahead circular FIFO for report payload words */

`timescale 1ns/100ps

module da_payload_fifo #(
    parameter int PAYLOAD_DEPTH = 32
) (
    input  logic                     clk_core,
    input  logic                     reset,
    input  logic                     push,
    input  da_proto_pkg::host_word_t push_word,
    input  logic                     pop,
    output da_proto_pkg::host_word_t head_word,
    output logic                     empty
);

    localparam int AW = $clog2(PAYLOAD_DEPTH);

    da_proto_pkg::host_word_t mem [PAYLOAD_DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          full;

    // Head is visible without a pop
    assign head_word = mem[rd_ptr];
    assign empty     = (count == '0);
    assign full      = (count == (AW+1)'(PAYLOAD_DEPTH));

    // Payload storage
    always_ff @(posedge clk_core) begin
        if (push) begin
            mem[wr_ptr] <= push_word;
        end
    end

    always_ff @(posedge clk_core) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Pointers wrap on their own since the depth is a power of two
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Parser must hold back pushes until there is room
    a_no_push_full: assert property (
        @(posedge clk_core) disable iff (reset) push |-> !full
    );

    // Framer pops only words that are there
    a_no_pop_empty: assert property (
        @(posedge clk_core) disable iff (reset) pop |-> !empty
    );

endmodule

//--- src/da_report_pkg.sv
/* Internal report request and control write strobe types */

package da_report_pkg;

    // Request handed from parser to framer with report_start
    typedef struct packed {
        logic [7:0]                slot;
        logic [7:0]                code;
        da_proto_pkg::report_len_t len;
    } report_req_t;

    // Control write strobe, one beat per data word
    typedef struct packed {
        logic                     valid;
        logic [7:0]               slot;
        da_proto_pkg::host_word_t data;
    } ctl_write_t;

endpackage

//--- src/da_proto_pkg.sv
/* Host protocol definitions: stream word types, command and report codes,
   header and footer layout of host packets and reports */

package da_proto_pkg;

    // One word on the host streams
    typedef logic [15:0] host_word_t;

    // Host stream beat, valid travels with the data word
    typedef struct packed {
        logic       valid;
        host_word_t data;
    } host_stream_t;

    // Sum of report or packet words, wraps at 32 bits
    typedef logic [31:0] checksum_t;

    // Report length in payload words, sent as two header words
    typedef logic [23:0] report_len_t;

    // Command codes, low byte of the command word
    localparam logic [7:0] CMD_DIRCHAN_READ = 8'h10;
    localparam logic [7:0] CMD_CTL_WRITE    = 8'h20;
    localparam logic [7:0] CMD_ECHO_SEND    = 8'h40;

    // Report codes, second word of every report
    localparam logic [7:0] RPT_DIRCHAN        = 8'h11;
    localparam logic [7:0] RPT_CHECKSUM_ERROR = 8'h21;
    localparam logic [7:0] RPT_ECHO           = 8'h41;

    // Report header is slot, code, length high, length low
    localparam int HEADER_WORDS = 4;

    // Length field of a control write packet
    localparam int LENGTH_WORDS = 2;

    // Checksum is carried high word first
    localparam int CHECKSUM_WORDS = 2;

endpackage
